//--- rtl/cast_pkg.sv
// Conversion slice package
// Widths, FP field constants, vector types and the operation encoding
// used by the lanes, the target bypass and the result packer

`default_nettype none

package cast_pkg;

  // --------------------
  // Datapath sizing
  // --------------------
  localparam int unsigned WIDTH         = 64;
  localparam int unsigned NUM_LANES     = 2;
  localparam int unsigned NUM_PIPE_REGS = 2;

  // --------------------
  // FP field constants
  // --------------------
  // Biases stay signed so that unbiased exponents can go negative
  localparam int FP32_EXP_BIAS = 127;
  localparam int FP16_EXP_BIAS = 15;

  localparam int unsigned FP32_MAN_BITS = 23;
  localparam int unsigned FP16_MAN_BITS = 10;

  // --------------------
  // Vector types
  // --------------------
  typedef logic [WIDTH-1:0] word_t;
  typedef logic [31:0]      fp32_t;
  typedef logic [15:0]      fp16_t;

  // IEEE flags from bit 4 down are invalid, divide-by-zero, overflow, underflow and inexact
  typedef logic [4:0] status_t;

  // Result information bits are is_vector, is_cpk and cpk_high
  typedef logic [2:0] result_aux_t;

  // Canonical quiet NaN and largest finite magnitude of FP16
  localparam fp16_t       FP16_QNAN       = 16'h7E00;
  localparam logic [14:0] FP16_MAX_FINITE = 15'h7BFF;

  // --------------------
  // Operations
  // --------------------
  typedef enum logic [1:0] {
    OP_F2F,
    // Pack into bits 31:0 of operand C
    OP_CPKAB,
    // Pack into bits 63:32 of operand C
    OP_CPKCD
  } conv_op_e;

endpackage

`default_nettype wire

//--- rtl/cast_lane.sv
// FP32 to FP16 down-cast lane
// Converts with round-toward-zero and flushes FP16 subnormals to zero,
// then carries result and flags through a valid/ready register pipeline

`timescale 1ns/1ps
`default_nettype none

module cast_lane (
  input  logic              clk_i,
  input  logic              reset_i,
  // Input side
  input  cast_pkg::fp32_t   operand_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  // Output side
  output cast_pkg::fp16_t   result_o,
  output cast_pkg::status_t status_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  // Source fields
  logic                               src_sign;
  logic [7:0]                         src_exp;
  logic [cast_pkg::FP32_MAN_BITS-1:0] src_man;
  logic                               src_is_nan;
  logic                               src_is_inf;
  logic                               src_is_zero;
  int                                 exp_unbiased;
  logic [4:0]                         dst_exp;

  cast_pkg::fp16_t   conv_result;
  cast_pkg::status_t conv_status;

  // Index i of the pipeline holds the value after i register stages
  cast_pkg::fp16_t   [0:cast_pkg::NUM_PIPE_REGS]   stage_result;
  cast_pkg::status_t [0:cast_pkg::NUM_PIPE_REGS]   stage_status;
  logic              [0:cast_pkg::NUM_PIPE_REGS]   stage_valid;
  logic              [0:cast_pkg::NUM_PIPE_REGS-1] stage_ready;

  // --------------------
  // Field decode
  // --------------------
  assign src_sign = operand_i[31];
  assign src_exp  = operand_i[30:cast_pkg::FP32_MAN_BITS];
  assign src_man  = operand_i[cast_pkg::FP32_MAN_BITS-1:0];

  assign src_is_nan  = (&src_exp) & (|src_man);
  assign src_is_inf  = (&src_exp) & ~(|src_man);
  assign src_is_zero = (src_exp == 8'h00) & ~(|src_man);

  assign exp_unbiased = int'(src_exp) - cast_pkg::FP32_EXP_BIAS;
  // Only meaningful inside the FP16 normal range
  assign dst_exp      = 5'(exp_unbiased + cast_pkg::FP16_EXP_BIAS);

  // --------------------
  // Down-cast
  // --------------------
  always_comb begin
    conv_result = '0;
    conv_status = '0;
    if (src_is_nan) begin
      conv_result    = cast_pkg::FP16_QNAN;
      // Signalling NaN has the quiet bit clear
      conv_status[4] = ~src_man[cast_pkg::FP32_MAN_BITS-1];
    end else if (src_is_inf) begin
      conv_result = {src_sign, 5'b11111, {cast_pkg::FP16_MAN_BITS{1'b0}}};
    end else if (exp_unbiased > cast_pkg::FP16_EXP_BIAS) begin
      // RTZ never rounds up to infinity
      conv_result = {src_sign, cast_pkg::FP16_MAX_FINITE};
      conv_status = 5'b00101;
    end else if (exp_unbiased < 1 - cast_pkg::FP16_EXP_BIAS) begin
      // Zero, FP32 subnormals and values below the FP16 normal range
      conv_result = {src_sign, 15'b0};
      conv_status = {3'b000, ~src_is_zero, ~src_is_zero};
    end else begin
      conv_result    = {src_sign, dst_exp,
                        src_man[cast_pkg::FP32_MAN_BITS-1 -: cast_pkg::FP16_MAN_BITS]};
      // Inexact when any truncated bit is set
      conv_status[0] =
          |src_man[cast_pkg::FP32_MAN_BITS-cast_pkg::FP16_MAN_BITS-1:0];
    end
  end

  // --------------------
  // Pipeline
  // --------------------
  assign stage_result[0] = conv_result;
  assign stage_status[0] = conv_status;
  assign stage_valid[0]  = in_valid_i;

  for (genvar i = 0; i < cast_pkg::NUM_PIPE_REGS; i++) begin : gen_stage
    // Advance when the output pops or any later stage holds a bubble
    assign stage_ready[i] = out_ready_i | ~(&stage_valid[i+1:cast_pkg::NUM_PIPE_REGS]);

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    // Payload only loads when a valid item moves in
    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && stage_valid[i]) begin
        stage_result[i+1] <= stage_result[i];
        stage_status[i+1] <= stage_status[i];
      end
    end
  end

  assign in_ready_o  = stage_ready[0];
  assign result_o    = stage_result[cast_pkg::NUM_PIPE_REGS];
  assign status_o    = stage_status[cast_pkg::NUM_PIPE_REGS];
  assign out_valid_o = stage_valid[cast_pkg::NUM_PIPE_REGS];

endmodule

`default_nettype wire

//--- rtl/cast_target_bypass.sv
// Target operand bypass
// Carries operand C and the result information of each operation
// through the same stage and ready chain as the lanes

`timescale 1ns/1ps
`default_nettype none

module cast_target_bypass (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Input side, accepted together with lane 0
  input  cast_pkg::word_t       target_i,
  input  cast_pkg::result_aux_t aux_i,
  input  logic                  in_valid_i,
  // Output side
  output cast_pkg::word_t       target_o,
  output cast_pkg::result_aux_t aux_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i
);

  // Index i holds the value after i register stages
  cast_pkg::word_t       [0:cast_pkg::NUM_PIPE_REGS]   byp_target;
  cast_pkg::result_aux_t [0:cast_pkg::NUM_PIPE_REGS]   byp_aux;
  logic                  [0:cast_pkg::NUM_PIPE_REGS]   byp_valid;
  logic                  [0:cast_pkg::NUM_PIPE_REGS-1] byp_ready;

  assign byp_target[0] = target_i;
  assign byp_aux[0]    = aux_i;
  assign byp_valid[0]  = in_valid_i;

  // --------------------
  // Register stages
  // --------------------
  for (genvar i = 0; i < cast_pkg::NUM_PIPE_REGS; i++) begin : gen_stage
    // Same downstream ready as lane 0 keeps both in step
    assign byp_ready[i] = out_ready_i | ~(&byp_valid[i+1:cast_pkg::NUM_PIPE_REGS]);

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        byp_valid[i+1] <= 1'b0;
      end else if (byp_ready[i]) begin
        byp_valid[i+1] <= byp_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (byp_ready[i] && byp_valid[i]) begin
        byp_target[i+1] <= byp_target[i];
        byp_aux[i+1]    <= byp_aux[i];
      end
    end
  end

  assign target_o    = byp_target[cast_pkg::NUM_PIPE_REGS];
  assign aux_o       = byp_aux[cast_pkg::NUM_PIPE_REGS];
  assign out_valid_o = byp_valid[cast_pkg::NUM_PIPE_REGS];

endmodule

`default_nettype wire

//--- rtl/cast_result_packer.sv
// Result packer
// Assembles the 64-bit result from the lane outputs by operation type,
// merges the lane flags and drives the output handshake

`timescale 1ns/1ps
`default_nettype none

module cast_result_packer (
  // Lane outputs
  input  cast_pkg::fp16_t       lane0_result_i,
  input  cast_pkg::fp16_t       lane1_result_i,
  input  cast_pkg::status_t     lane0_status_i,
  input  cast_pkg::status_t     lane1_status_i,
  input  logic                  lane0_valid_i,
  // Bypass outputs
  input  cast_pkg::word_t       target_i,
  input  cast_pkg::result_aux_t aux_i,
  // Ready fan-out
  input  logic                  out_ready_i,
  output logic                  lane0_ready_o,
  output logic                  lane1_ready_o,
  output logic                  bypass_ready_o,
  // Slice output
  output cast_pkg::word_t       result_o,
  output cast_pkg::status_t     status_o,
  output logic                  out_valid_o
);

  logic is_vector;
  logic is_cpk;
  logic cpk_high;

  // Lane 1 result sits above lane 0
  cast_pkg::fp16_t [cast_pkg::NUM_LANES-1:0] lane_pair;

  cast_pkg::word_t scalar_word;
  cast_pkg::word_t vector_word;
  cast_pkg::word_t cpk_word;

  assign {is_vector, is_cpk, cpk_high} = aux_i;
  assign lane_pair = {lane1_result_i, lane0_result_i};

  // --------------------
  // Result assembly
  // --------------------
  // NaN-box the unused upper bits with ones
  assign scalar_word =
      {{(cast_pkg::WIDTH - $bits(cast_pkg::fp16_t)){1'b1}}, lane0_result_i};
  assign vector_word =
      {{(cast_pkg::WIDTH - $bits(lane_pair)){1'b1}}, lane_pair};

  // Operand C is preloaded, then one half is overwritten
  always_comb begin
    cpk_word = target_i;
    if (cpk_high) begin
      cpk_word[cast_pkg::WIDTH-1 -: $bits(lane_pair)] = lane_pair;
    end else begin
      cpk_word[$bits(lane_pair)-1:0] = lane_pair;
    end
  end

  assign result_o = is_cpk    ? cpk_word    :
                    is_vector ? vector_word :
                                scalar_word;

  // Lane 1 flags only count for vector operations
  assign status_o = lane0_status_i
                  | (lane1_status_i & {$bits(cast_pkg::status_t){is_vector}});

  // --------------------
  // Handshake
  // --------------------
  assign out_valid_o    = lane0_valid_i;
  assign lane0_ready_o  = out_ready_i;
  assign bypass_ready_o = out_ready_i;
  // Lane 1 only pops when the operation at the output used it
  assign lane1_ready_o  = out_ready_i & is_vector;

endmodule

`default_nettype wire

//--- rtl/cast_slice.sv
// Two-lane FP32 to FP16 conversion slice
// Steers operands into the lanes, sends operand C down the bypass
// and packs the lane results into one 64-bit result

`timescale 1ns/1ps
`default_nettype none

module cast_slice (
  input  logic                 clk_i,
  input  logic                 reset_i,
  // Operation
  input  cast_pkg::word_t      operands_a_i,
  input  cast_pkg::word_t      operands_b_i,
  input  cast_pkg::word_t      operands_c_i,
  input  cast_pkg::conv_op_e   op_i,
  input  logic                 vectorial_i,
  // Input handshake
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  // Result
  output cast_pkg::word_t      result_o,
  output cast_pkg::status_t    status_o,
  // Output handshake
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);

  logic                  is_vector;
  logic                  is_cpk;
  logic                  cpk_high;
  cast_pkg::result_aux_t aux_in;

  cast_pkg::fp32_t   lane1_operand;
  logic              lane1_in_valid;

  cast_pkg::fp16_t   lane0_result;
  cast_pkg::fp16_t   lane1_result;
  cast_pkg::status_t lane0_status;
  cast_pkg::status_t lane1_status;
  logic              lane0_out_valid;
  logic              lane0_out_ready;
  logic              lane1_out_ready;

  cast_pkg::word_t       byp_target;
  cast_pkg::result_aux_t byp_aux;
  logic                  byp_out_ready;

  // --------------------
  // Input side
  // --------------------
  assign is_cpk    = (op_i == cast_pkg::OP_CPKAB) | (op_i == cast_pkg::OP_CPKCD);
  assign cpk_high  = (op_i == cast_pkg::OP_CPKCD);
  // Cast-and-pack always uses both lanes
  assign is_vector = vectorial_i | is_cpk;
  assign aux_in    = {is_vector, is_cpk, cpk_high};

  // Second cast source is operand B for cast-and-pack
  assign lane1_operand  = is_cpk ? operands_b_i[31:0] : operands_a_i[63:32];
  assign lane1_in_valid = in_valid_i & is_vector;

  cast_lane u_lane0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .operand_i   (operands_a_i[31:0]),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (lane0_result),
    .status_o    (lane0_status),
    .out_valid_o (lane0_out_valid),
    .out_ready_i (lane0_out_ready)
  );

  // Lane 1 handshakes follow lane 0 and the bypass, so its own are left open
  cast_lane u_lane1 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .operand_i   (lane1_operand),
    .in_valid_i  (lane1_in_valid),
    .in_ready_o  (),
    .result_o    (lane1_result),
    .status_o    (lane1_status),
    .out_valid_o (),
    .out_ready_i (lane1_out_ready)
  );

  cast_target_bypass u_bypass (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .target_i    (operands_c_i),
    .aux_i       (aux_in),
    .in_valid_i  (in_valid_i),
    .target_o    (byp_target),
    .aux_o       (byp_aux),
    .out_valid_o (),
    .out_ready_i (byp_out_ready)
  );

  // --------------------
  // Output side
  // --------------------
  cast_result_packer u_packer (
    .lane0_result_i (lane0_result),
    .lane1_result_i (lane1_result),
    .lane0_status_i (lane0_status),
    .lane1_status_i (lane1_status),
    .lane0_valid_i  (lane0_out_valid),
    .target_i       (byp_target),
    .aux_i          (byp_aux),
    .out_ready_i    (out_ready_i),
    .lane0_ready_o  (lane0_out_ready),
    .lane1_ready_o  (lane1_out_ready),
    .bypass_ready_o (byp_out_ready),
    .result_o       (result_o),
    .status_o       (status_o),
    .out_valid_o    (out_valid_o)
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// Testbench clock and reset generator
// 10 ns clock, synchronous reset held high for the first three rising edges

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Release a little after the edge, like every other driven input
  initial begin
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- test/cast_slice_tb.sv
// Conversion slice testbench
// Reads operations and expected results from the stimulus file, runs them
// once with the output always ready and once under random back-pressure,
// and checks value, flags, order and latency of every result

`timescale 1ns/1ps
`default_nettype none

module cast_slice_tb;

  localparam string STIM_FILE        = "test/cast_slice_stimulus.txt";
  localparam int    MAX_VECTORS      = 64;
  localparam int    NUM_PASSES       = 2;
  localparam int    EXPECTED_LATENCY = 2;

  logic               clk;
  logic               reset;
  cast_pkg::word_t    operands_a;
  cast_pkg::word_t    operands_b;
  cast_pkg::word_t    operands_c;
  cast_pkg::conv_op_e op;
  logic               vectorial;
  logic               in_valid;
  logic               in_ready;
  cast_pkg::word_t    result;
  cast_pkg::status_t  status;
  logic               out_valid;
  logic               out_ready;

  // Vector table
  string             vec_name       [MAX_VECTORS];
  logic [1:0]        vec_op         [MAX_VECTORS];
  logic              vec_vectorial  [MAX_VECTORS];
  cast_pkg::word_t   vec_a          [MAX_VECTORS];
  cast_pkg::word_t   vec_b          [MAX_VECTORS];
  cast_pkg::word_t   vec_c          [MAX_VECTORS];
  cast_pkg::word_t   vec_exp_result [MAX_VECTORS];
  cast_pkg::status_t vec_exp_status [MAX_VECTORS];
  int                num_vectors;
  bit                vectors_loaded;

  // Scoreboard, one entry per accepted operation
  int exp_idx_q[$];
  int accept_cycle_q[$];
  int accept_pass_q[$];

  int          drv_idx;
  int          drv_pass;
  bit          input_taken;
  int          cycle_count;
  int          tests_run;
  int          tests_failed;
  int          error_count;
  logic [31:0] lcg_state;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  cast_slice dut0 (
    .clk_i        (clk),
    .reset_i      (reset),
    .operands_a_i (operands_a),
    .operands_b_i (operands_b),
    .operands_c_i (operands_c),
    .op_i         (op),
    .vectorial_i  (vectorial),
    .in_valid_i   (in_valid),
    .in_ready_o   (in_ready),
    .result_o     (result),
    .status_o     (status),
    .out_valid_o  (out_valid),
    .out_ready_i  (out_ready)
  );

  function automatic logic [31:0] next_lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic read_vectors();
    int                fd;
    int                fields;
    string             line;
    logic [8*32-1:0]   name_buf;
    logic [1:0]        op_buf;
    logic              vec_buf;
    cast_pkg::word_t   a_buf;
    cast_pkg::word_t   b_buf;
    cast_pkg::word_t   c_buf;
    cast_pkg::word_t   res_buf;
    cast_pkg::status_t st_buf;
    num_vectors = 0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file %s", STIM_FILE);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Skip comments and blank lines
      if (line.len() > 1 && line[0] != "#" && num_vectors < MAX_VECTORS) begin
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h", name_buf, op_buf, vec_buf,
                         a_buf, b_buf, c_buf, res_buf, st_buf);
        if (fields == 8) begin
          vec_name[num_vectors]       = string'(name_buf);
          vec_op[num_vectors]         = op_buf;
          vec_vectorial[num_vectors]  = vec_buf;
          vec_a[num_vectors]          = a_buf;
          vec_b[num_vectors]          = b_buf;
          vec_c[num_vectors]          = c_buf;
          vec_exp_result[num_vectors] = res_buf;
          vec_exp_status[num_vectors] = st_buf;
          num_vectors++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Pass 0 keeps the output ready, later passes stall it at random
  task automatic update_out_ready(input int pass);
    if (pass == 0) begin
      out_ready = 1'b1;
    end else begin
      lcg_state = next_lcg(lcg_state);
      out_ready = lcg_state[20];
    end
  endtask

  task automatic apply_vector(input int idx, input int pass);
    operands_a = vec_a[idx];
    operands_b = vec_b[idx];
    operands_c = vec_c[idx];
    op         = cast_pkg::conv_op_e'(vec_op[idx]);
    vectorial  = vec_vectorial[idx];
    drv_idx    = idx;
    drv_pass   = pass;
    in_valid   = 1'b1;
  endtask

  task automatic check_output();
    int vi;
    int acc_cycle;
    int acc_pass;
    bit ok;
    if (exp_idx_q.size() == 0) begin
      $display("Result %h came out with no operation pending", result);
      error_count++;
      return;
    end
    vi        = exp_idx_q.pop_front();
    acc_cycle = accept_cycle_q.pop_front();
    acc_pass  = accept_pass_q.pop_front();
    ok        = 1'b1;
    if (result !== vec_exp_result[vi]) begin
      $display("MISMATCH %s result expected %h actual %h",
               vec_name[vi], vec_exp_result[vi], result);
      ok = 1'b0;
    end
    if (status !== vec_exp_status[vi]) begin
      $display("MISMATCH %s status expected %h actual %h",
               vec_name[vi], vec_exp_status[vi], status);
      ok = 1'b0;
    end
    // Latency only holds while the output never stalls
    if (acc_pass == 0 && cycle_count - acc_cycle != EXPECTED_LATENCY) begin
      $display("MISMATCH %s latency expected %0d actual %0d",
               vec_name[vi], EXPECTED_LATENCY, cycle_count - acc_cycle);
      ok = 1'b0;
    end
    tests_run++;
    if (ok) begin
      $display("test %s pass %0d: ok", vec_name[vi], acc_pass);
    end else begin
      $display("test %s pass %0d: failed", vec_name[vi], acc_pass);
      tests_failed++;
      error_count++;
    end
  endtask

  // --------------------
  // Monitor
  // --------------------
  // Sampled mid-cycle, so both handshakes are settled
  always @(negedge clk) begin
    if (!reset) begin
      cycle_count++;
      input_taken = in_valid && in_ready;
      if (input_taken) begin
        exp_idx_q.push_back(drv_idx);
        accept_cycle_q.push_back(cycle_count);
        accept_pass_q.push_back(drv_pass);
      end
      if (out_valid && out_ready) begin
        check_output();
      end
    end
  end

  // --------------------
  // Driver
  // --------------------
  initial begin
    int pass;
    int idx;
    operands_a     = '0;
    operands_b     = '0;
    operands_c     = '0;
    op             = cast_pkg::OP_F2F;
    vectorial      = 1'b0;
    in_valid       = 1'b0;
    out_ready      = 1'b0;
    drv_idx        = 0;
    drv_pass       = 0;
    input_taken    = 1'b0;
    cycle_count    = 0;
    tests_run      = 0;
    tests_failed   = 0;
    error_count    = 0;
    vectors_loaded = 1'b0;
    lcg_state      = 32'h42e3_9f4f;
    read_vectors();
    if (num_vectors == 0) begin
      $display("No operations were read from %s", STIM_FILE);
      error_count++;
    end else begin
      vectors_loaded = 1'b1;
      do @(negedge clk); while (reset);
      if (out_valid !== 1'b0) begin
        $display("out_valid_o is not low right after reset");
        error_count++;
      end
      for (pass = 0; pass < NUM_PASSES; pass++) begin
        idx = 0;
        // Valid holds its operation until the DUT takes it
        while (idx < num_vectors) begin
          @(posedge clk);
          #1;
          update_out_ready(pass);
          if (in_valid && input_taken) begin
            in_valid = 1'b0;
            idx++;
          end
          if (!in_valid && idx < num_vectors) begin
            apply_vector(idx, pass);
          end
        end
        while (exp_idx_q.size() != 0) begin
          @(posedge clk);
          #1;
          update_out_ready(pass);
        end
      end
      // Any result after the last expected one is a stray
      out_ready = 1'b1;
      repeat (EXPECTED_LATENCY + 2) @(posedge clk);
    end
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the number of operations
  initial begin
    wait (vectors_loaded);
    repeat (num_vectors * 20 + 100) @(posedge clk);
    $display("Timeout after %0d cycles with %0d results still pending",
             num_vectors * 20 + 100, exp_idx_q.size());
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/cast_slice_stimulus.txt
# name op vectorial operand_a operand_b operand_c expected_result expected_status, all in hex
# op 0 = F2F, 1 = CPKAB, 2 = CPKCD; status bits are invalid, div-zero, overflow, underflow, inexact
one 0 0 000000003F800000 0000000000000000 0000000000000000 FFFFFFFFFFFF3C00 00
one_and_half 0 0 000000003FC00000 0000000000000000 0000000000000000 FFFFFFFFFFFF3E00 00
trunc_inexact 0 0 000000003F800001 0000000000000000 0000000000000000 FFFFFFFFFFFF3C00 01
neg_pi 0 0 00000000C0490FDB 0000000000000000 0000000000000000 FFFFFFFFFFFFC248 01
max_finite 0 0 00000000477FE000 0000000000000000 0000000000000000 FFFFFFFFFFFF7BFF 00
max_trunc 0 0 00000000477FFFFF 0000000000000000 0000000000000000 FFFFFFFFFFFF7BFF 01
overflow 0 0 0000000047800000 0000000000000000 0000000000000000 FFFFFFFFFFFF7BFF 05
neg_overflow 0 0 00000000C7800000 0000000000000000 0000000000000000 FFFFFFFFFFFFFBFF 05
min_normal 0 0 0000000038800000 0000000000000000 0000000000000000 FFFFFFFFFFFF0400 00
tiny 0 0 0000000038000000 0000000000000000 0000000000000000 FFFFFFFFFFFF0000 03
neg_tiny 0 0 00000000B8000000 0000000000000000 0000000000000000 FFFFFFFFFFFF8000 03
zero 0 0 0000000000000000 0000000000000000 0000000000000000 FFFFFFFFFFFF0000 00
neg_zero 0 0 0000000080000000 0000000000000000 0000000000000000 FFFFFFFFFFFF8000 00
fp32_subnormal 0 0 0000000000000001 0000000000000000 0000000000000000 FFFFFFFFFFFF0000 03
qnan 0 0 000000007FC00000 0000000000000000 0000000000000000 FFFFFFFFFFFF7E00 00
snan 0 0 000000007F800001 0000000000000000 0000000000000000 FFFFFFFFFFFF7E00 10
neg_qnan 0 0 00000000FFC00001 0000000000000000 0000000000000000 FFFFFFFFFFFF7E00 00
inf 0 0 000000007F800000 0000000000000000 0000000000000000 FFFFFFFFFFFF7C00 00
neg_inf 0 0 00000000FF800000 0000000000000000 0000000000000000 FFFFFFFFFFFFFC00 00
scalar_upper_ignored 0 0 7F8000013F800000 0000000000000000 0000000000000000 FFFFFFFFFFFF3C00 00
vec_basic 0 1 400000003F800000 0000000000000000 0000000000000000 FFFFFFFF40003C00 00
vec_neg 0 1 C0000000BF800000 0000000000000000 0000000000000000 FFFFFFFFC000BC00 00
vec_flags 0 1 478000003F800001 0000000000000000 0000000000000000 FFFFFFFF7BFF3C00 05
vec_nan_tiny 0 1 7F80000138000000 0000000000000000 0000000000000000 FFFFFFFF7E000000 13
cpkab 1 0 000000003F800000 0000000040000000 0123456789ABCDEF 0123456740003C00 00
cpkcd 2 0 000000003F800000 0000000040000000 0123456789ABCDEF 40003C0089ABCDEF 00
cpkab_flags 1 0 000000003F800001 00000000C7800000 FEDCBA9876543210 FEDCBA98FBFF3C00 05
cpkcd_flags 2 0 0000000000000001 00000000FF800000 FEDCBA9876543210 FC00000076543210 03
cpk_b_select 1 1 478000003F800000 FFFFFFFF40000000 0000000000000000 0000000040003C00 00

//--- flist.f
rtl/cast_pkg.sv
rtl/cast_lane.sv
rtl/cast_target_bypass.sv
rtl/cast_result_packer.sv
rtl/cast_slice.sv
test/tb_clock_gen.sv
test/cast_slice_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the conversion slice testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module cast_slice_tb -o cast_slice_sim \
  && ./obj_dir/cast_slice_sim | tee /dev/stderr | grep -qx "STATUS: PASS" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
